/* cart_pkg.sv */
/*
 * Shared types and constants for the freeze cartridge controller.
 * Every cartridge module imports this package in its header.
 * Vector types carry the CPU bus widths and the register encodings.
 */

`default_nettype none

package cart_pkg;

	// cpu word address, byte lane bit 0 is not on the bus
	typedef logic [23:1] cpu_addr_t;

	// one 16-bit data bus word
	typedef logic [15:0] word_t;

	// custom register word index on the register bus
	typedef logic [7:0] reg_addr_t;

	// mode register, bit 1 enables the breakpoint logic
	typedef logic [1:0] mode_t;

	// status register as seen by the cartridge rom
	typedef logic [1:0] status_t;

	// level 7 interrupt handshake states
	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_REQ,
		IRQ_RELEASE
	} irq_state_t;

	// address bits 17..9 of the shadow window in cartridge ram
	localparam logic [8:0] SHADOW_WINDOW = 9'b001111000;

	// reset vector fetch, byte address 8
	localparam cpu_addr_t RESET_VEC_WORD = 23'd4;

	// upper address bits that are zero in the low 1 KB
	localparam int LOW_AREA_BITS = 14;

	// register values after reset and after each event
	localparam mode_t MODE_RESET = 2'b11;
	localparam status_t STATUS_RESET = 2'b11;
	localparam status_t STATUS_FREEZE = 2'b00;
	localparam status_t STATUS_BREAK = 2'b01;

endpackage

`default_nettype wire

/* cart_decode.sv */
/*
 * Address decoder of the cartridge window.
 * Turns the cpu address into the rom, ram, shadow, mode and status
 * selects and drives selmem to the external memory. Purely combinational.
 */

`default_nettype none

module cart_decode
	import cart_pkg::*;
#(
	parameter logic [4:0] CART_REGION = 5'd8
) (
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_rd,
	input  logic      dbr,
	input  logic      boot,
	input  logic      aron,
	input  logic      ovr,
	output logic      sel_rom,
	output logic      sel_ram,
	output logic      sel_custom,
	output logic      sel_mode,
	output logic      sel_status,
	output logic      selmem
);

	logic sel_cart;
	logic in_shadow;
	logic sel_ovl;

	// whole 512 KB window, only once armed and never for dma cycles
	assign sel_cart = aron & ~dbr & (cpu_addr[23:19] == CART_REGION);

	// shadow window sits inside the upper half
	assign in_shadow = (cpu_addr[17:9] == SHADOW_WINDOW);

	// lower half is rom
	// first two words are taken by the mode and status registers
	assign sel_rom = sel_cart & ~cpu_addr[18] & (|cpu_addr[17:2]);

	// upper half is ram with a hole for the shadow window
	assign sel_ram = sel_cart & cpu_addr[18] & ~in_shadow;

	// shadow answers reads only, writes go nowhere
	assign sel_custom = sel_cart & cpu_addr[18] & in_shadow & cpu_rd;

	// mode register is word 0
	assign sel_mode = sel_cart & ~(|cpu_addr[18:1]);

	// status repeats over words 0 and 1 on reads
	assign sel_status = sel_cart & ~(|cpu_addr[18:2]) & cpu_rd;

	// overlay of the lowest 512 KB while the interrupt is serviced
	// shows the cartridge rom where the vectors live
	assign sel_ovl = ovr & (cpu_addr[23:19] == 5'd0) & cpu_rd;

	// rom takes writes only during boot so the loader can fill it
	always_comb begin
		selmem = 1'b0;
		if (sel_rom && boot)
			selmem = 1'b1;
		if (sel_rom && cpu_rd)
			selmem = 1'b1;
		if (sel_ram || sel_ovl)
			selmem = 1'b1;
	end

endmodule

`default_nettype wire

/* cart_regs.sv */
/*
 * Register block of the cartridge.
 * Holds the arm flag, mode, status, active and overlay flags that steer
 * the interrupt logic, and registers the read data seen by the cpu.
 */

`default_nettype none

module cart_regs
	import cart_pkg::*;
#(
	parameter logic [4:0] CART_REGION = 5'd8
) (
	input  logic      clk,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_hwr,
	input  logic      cpu_lwr,
	input  logic      cpu_rd,
	input  logic      boot,
	input  word_t     data_in,
	input  logic      sel_rom,
	input  logic      sel_mode,
	input  logic      sel_status,
	input  logic      freeze_evt,
	input  logic      break_evt,
	input  logic      irq_done,
	input  word_t     shadow_word,
	output logic      aron,
	output logic      ovr,
	output logic      active,
	output logic      mode_brk,
	output word_t     data_out
);

	mode_t   mode;
	status_t status;
	status_t status_rd;
	logic    any_wr;

	assign any_wr = cpu_hwr | cpu_lwr;

	// the boot loader writing the rom image arms the cartridge
	// decode is not armed yet, so the rom half is matched here
	always_ff @(posedge clk) begin
		if (reset)
			aron <= 1'b0;
		else if (boot && cpu_lwr && (cpu_addr[23:18] == {CART_REGION, 1'b0}))
			aron <= 1'b1;
	end

	// bit 1 turns the breakpoint on
	always_ff @(posedge clk) begin
		if (reset)
			mode <= MODE_RESET;
		else if (sel_mode && cpu_lwr)
			mode <= data_in[1:0];
	end

	assign mode_brk = mode[1];

	// set once the interrupt is taken
	// the rom leaves the freeze by writing the mode register
	always_ff @(posedge clk) begin
		if (reset)
			active <= 1'b0;
		else if (irq_done)
			active <= 1'b1;
		else if (sel_mode && any_wr)
			active <= 1'b0;
	end

	// low memory overlay for the interrupt vector fetch
	// cleared by the rom writing word 3
	always_ff @(posedge clk) begin
		if (reset)
			ovr <= 1'b0;
		else if (irq_done)
			ovr <= 1'b1;
		else if (sel_rom && any_wr && (cpu_addr[17:1] == 17'd3))
			ovr <= 1'b0;
	end

	// tells the rom why it was entered
	always_ff @(posedge clk) begin
		if (reset)
			status <= STATUS_RESET;
		else if (freeze_evt)
			status <= STATUS_FREEZE;
		else if (break_evt)
			status <= STATUS_BREAK;
	end

	// read side, one clock behind the address like the shadow ram
	always_ff @(posedge clk) begin
		if (sel_status && cpu_rd)
			status_rd <= status;
		else
			status_rd <= '0;
	end

	// shadow word is already zero outside the shadow window
	assign data_out = {{14{1'b0}}, status_rd} | shadow_word;

endmodule

`default_nettype wire

/* cart_irq.sv */
/*
 * Level 7 interrupt logic.
 * Detects the freeze button edge, the first reset vector fetch and
 * breakpoint hits, then runs the four-phase int7/iack handshake.
 * irq_done tells the register block that the interrupt was taken.
 */

`default_nettype none

module cart_irq
	import cart_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_as,
	input  logic      boot,
	input  logic      aron,
	input  logic      active,
	input  logic      freeze,
	input  logic      break_hit,
	input  logic      iack,
	output logic      int7,
	output logic      freeze_evt,
	output logic      break_evt,
	output logic      irq_done
);

	irq_state_t state;
	logic       freeze_q;
	logic       after_reset;
	logic       reset_req;
	logic       irq_req;

	// previous freeze sample for edge detection
	always_ff @(posedge clk) begin
		if (reset)
			freeze_q <= 1'b0;
		else
			freeze_q <= freeze;
	end

	// button is ignored while the rom already runs
	assign freeze_evt = freeze & ~freeze_q & (~active | ~aron);

	// only an armed cartridge reacts to the watch address
	assign break_evt = break_hit & aron;

	// first reset vector fetch after a reset hands control to the rom
	always_ff @(posedge clk) begin
		if (reset)
			after_reset <= 1'b1;
		else if (irq_done)
			after_reset <= 1'b0;
	end

	assign reset_req = after_reset & cpu_as & (cpu_addr == RESET_VEC_WORD);

	// no interrupts while the loader is still filling the rom
	assign irq_req = ~boot & aron & (freeze_evt | reset_req | break_evt);

	// requests outside IRQ_IDLE are dropped
	// a new one waits until iack has been seen low
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IRQ_IDLE;
			irq_done <= 1'b0;
		end else begin
			irq_done <= 1'b0;
			case (state)
				IRQ_IDLE: begin
					if (irq_req)
						state <= IRQ_REQ;
				end
				IRQ_REQ: begin
					// int7 drops together with the done pulse
					if (iack) begin
						state <= IRQ_RELEASE;
						irq_done <= 1'b1;
					end
				end
				IRQ_RELEASE: begin
					if (!iack)
						state <= IRQ_IDLE;
				end
				default: state <= IRQ_IDLE;
			endcase
		end
	end

	assign int7 = (state == IRQ_REQ);

endmodule

`default_nettype wire

/* cart_break.sv */
/*
 * Breakpoint detector.
 * Fires when the watch address is accessed by a bus cycle that
 * directly follows a cycle in the low 1 KB of memory.
 * Enabled by bit 1 of the mode register.
 */

`default_nettype none

module cart_break
	import cart_pkg::*;
#(
	parameter cpu_addr_t BREAK_ADDR = 23'h5FF000
) (
	input  logic      clk,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_as,
	input  logic      mode_brk,
	output logic      break_hit
);

	logic as_q;
	logic cur_low;
	logic prev_low;

	// cur_low follows the running cycle, prev_low keeps the last ended one
	always_ff @(posedge clk) begin
		if (reset) begin
			as_q <= 1'b0;
			cur_low <= 1'b0;
			prev_low <= 1'b0;
		end else begin
			as_q <= cpu_as;
			if (cpu_as)
				cur_low <= (cpu_addr[23 -: LOW_AREA_BITS] == '0);
			// address strobe just ended
			if (as_q && !cpu_as)
				prev_low <= cur_low;
		end
	end

	assign break_hit = cpu_as & mode_brk & prev_low & (cpu_addr == BREAK_ADDR);

endmodule

`default_nettype wire

/* custom_shadow.sv */
/*
 * Shadow copy of the 256 custom chip registers.
 * Written from the register bus on every reg_we strobe, so dma writes
 * land here too. The cpu reads it through the shadow window one clock late.
 */

`default_nettype none

module custom_shadow
	import cart_pkg::*;
(
	input  logic      clk,
	input  logic      reg_we,
	input  reg_addr_t reg_addr,
	input  word_t     reg_data,
	input  cpu_addr_t cpu_addr,
	input  logic      sel_custom,
	output word_t     shadow_word
);

	word_t mem [256];
	word_t rd_word;
	logic  sel_q;

	// register bus write
	always_ff @(posedge clk) begin
		if (reg_we)
			mem[reg_addr] <= reg_data;
	end

	// synchronous read so the array maps onto block ram
	always_ff @(posedge clk) begin
		rd_word <= mem[cpu_addr[8:1]];
		sel_q <= sel_custom;
	end

	// zero outside the window lets data_out simply OR its sources
	assign shadow_word = sel_q ? rd_word : '0;

endmodule

`default_nettype wire

/* cart_top.sv */
/*
 * Top level of the freeze cartridge controller.
 * Wires the decoder, register block, interrupt logic, breakpoint
 * detector and custom register shadow, and sets their parameters.
 */

`default_nettype none

module cart_top
	import cart_pkg::*;
#(
	parameter logic [4:0] CART_REGION = 5'd8,
	parameter cpu_addr_t  BREAK_ADDR = 23'h5FF000
) (
	input  logic      clk,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_as,
	input  logic      cpu_rd,
	input  logic      cpu_hwr,
	input  logic      cpu_lwr,
	input  word_t     data_in,
	input  logic      dbr,
	input  logic      boot,
	input  logic      freeze,
	input  logic      iack,
	input  logic      reg_we,
	input  reg_addr_t reg_addr,
	input  word_t     reg_data,
	output word_t     data_out,
	output logic      selmem,
	output logic      int7,
	output logic      ovr,
	output logic      aron
);

	// decoder selects
	logic sel_rom;
	logic sel_ram;
	logic sel_custom;
	logic sel_mode;
	logic sel_status;

	// register block state
	logic active;
	logic mode_brk;

	// events between the interrupt logic and the registers
	logic freeze_evt;
	logic break_evt;
	logic irq_done;
	logic break_hit;

	word_t shadow_word;

	cart_decode #(
		.CART_REGION(CART_REGION)
	) u_decode (
		.cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .dbr(dbr), .boot(boot),
		.aron(aron), .ovr(ovr), .sel_rom(sel_rom), .sel_ram(sel_ram),
		.sel_custom(sel_custom), .sel_mode(sel_mode),
		.sel_status(sel_status), .selmem(selmem)
	);

	cart_regs #(
		.CART_REGION(CART_REGION)
	) u_regs (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_hwr(cpu_hwr),
		.cpu_lwr(cpu_lwr), .cpu_rd(cpu_rd), .boot(boot), .data_in(data_in),
		.sel_rom(sel_rom), .sel_mode(sel_mode), .sel_status(sel_status),
		.freeze_evt(freeze_evt), .break_evt(break_evt), .irq_done(irq_done),
		.shadow_word(shadow_word), .aron(aron), .ovr(ovr), .active(active),
		.mode_brk(mode_brk), .data_out(data_out)
	);

	cart_irq u_irq (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_as(cpu_as),
		.boot(boot), .aron(aron), .active(active), .freeze(freeze),
		.break_hit(break_hit), .iack(iack), .int7(int7),
		.freeze_evt(freeze_evt), .break_evt(break_evt), .irq_done(irq_done)
	);

	cart_break #(
		.BREAK_ADDR(BREAK_ADDR)
	) u_break (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_as(cpu_as),
		.mode_brk(mode_brk), .break_hit(break_hit)
	);

	custom_shadow u_shadow (
		.clk(clk), .reg_we(reg_we), .reg_addr(reg_addr), .reg_data(reg_data),
		.cpu_addr(cpu_addr), .sel_custom(sel_custom), .shadow_word(shadow_word)
	);

endmodule

`default_nettype wire

/* tb_cart.sv */
/*
 * Testbench of the freeze cartridge controller.
 * Builds a table of bus operations with expected responses, applies it in
 * a loop and checks selmem mid-cycle, then data_out, int7, ovr and aron
 * after the edge.
 */

`default_nettype none

module tb_cart
	import cart_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {
		OP_WRITE,
		OP_READ,
		OP_REGWR,
		OP_FREEZE,
		OP_IACK,
		OP_IDLE,
		OP_RESET
	} op_kind_t;

	// one bus operation and the responses expected after it
	typedef struct {
		string       name;
		op_kind_t    kind;
		logic        boot;
		logic [23:0] addr;
		word_t       data;
		word_t       exp_data;
		logic        exp_selmem;
		logic        exp_int7;
		logic        exp_ovr;
	} step_t;

	// byte addresses, the cartridge sits at 0x400000
	localparam logic [23:0] MODE_BYTE = 24'h400000;
	localparam logic [23:0] STATUS1_BYTE = 24'h400002;
	localparam logic [23:0] ROM_WORD3 = 24'h400006;
	localparam logic [23:0] ROM_BYTE = 24'h400100;
	// upper half at 0x440000, shadow window at offset 0xF000
	localparam logic [23:0] SHADOW_BASE = 24'h44F000;
	localparam logic [23:0] RAM_BYTE = 24'h44F200;
	localparam logic [23:0] LOW_BYTE = 24'h000100;
	localparam logic [23:0] VEC_BYTE = 24'h000008;
	localparam logic [23:0] BREAK_BYTE = 24'hBFE001;

	logic      clk = 1'b0;
	logic      reset;
	cpu_addr_t cpu_addr;
	logic      cpu_as;
	logic      cpu_rd;
	logic      cpu_hwr;
	logic      cpu_lwr;
	word_t     data_in;
	logic      dbr;
	logic      boot;
	logic      freeze;
	logic      iack;
	logic      reg_we;
	reg_addr_t reg_addr;
	word_t     reg_data;
	word_t     data_out;
	logic      selmem;
	logic      int7;
	logic      ovr;
	logic      aron;

	step_t  steps[$];
	word_t  shadow_model [256];
	integer seed = 84;
	int     cycle_count = 0;
	int     cycle_limit = 0;

	cart_top #(
		.CART_REGION(5'd8),
		.BREAK_ADDR(BREAK_BYTE[23:1])
	) dut (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_as(cpu_as),
		.cpu_rd(cpu_rd), .cpu_hwr(cpu_hwr), .cpu_lwr(cpu_lwr), .data_in(data_in),
		.dbr(dbr), .boot(boot), .freeze(freeze), .iack(iack), .reg_we(reg_we),
		.reg_addr(reg_addr), .reg_data(reg_data), .data_out(data_out),
		.selmem(selmem), .int7(int7), .ovr(ovr), .aron(aron)
	);

	always #5 clk = ~clk;

	// run limit from the table length
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d clock cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input string what,
			input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic add_step(input string name, input op_kind_t kind, input logic bt,
			input logic [23:0] addr, input word_t data, input word_t exp_data,
			input logic exp_selmem, input logic exp_int7, input logic exp_ovr);
		step_t s;
		s.name = name;
		s.kind = kind;
		s.boot = bt;
		s.addr = addr;
		s.data = data;
		s.exp_data = exp_data;
		s.exp_selmem = exp_selmem;
		s.exp_int7 = exp_int7;
		s.exp_ovr = exp_ovr;
		steps.push_back(s);
	endtask

	// all inputs quiet, only boot follows the table
	task automatic set_idle(input logic bt);
		cpu_addr = '0;
		cpu_as = 1'b0;
		cpu_rd = 1'b0;
		cpu_hwr = 1'b0;
		cpu_lwr = 1'b0;
		data_in = '0;
		dbr = 1'b0;
		boot = bt;
		freeze = 1'b0;
		iack = 1'b0;
		reg_we = 1'b0;
		reg_addr = '0;
		reg_data = '0;
	endtask

	// leaves the bus 1 ns after a rising edge with reset low
	task automatic pulse_reset();
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic drive_step(input step_t s);
		set_idle(s.boot);
		case (s.kind)
			OP_WRITE: begin
				cpu_as = 1'b1;
				cpu_lwr = 1'b1;
				cpu_addr = s.addr[23:1];
				data_in = s.data;
			end
			OP_READ: begin
				cpu_as = 1'b1;
				cpu_rd = 1'b1;
				cpu_addr = s.addr[23:1];
			end
			OP_REGWR: begin
				reg_we = 1'b1;
				reg_addr = s.addr[7:0];
				reg_data = s.data;
			end
			OP_FREEZE: freeze = 1'b1;
			OP_IACK: iack = 1'b1;
			OP_RESET: pulse_reset();
			default: ;
		endcase
	endtask

	task automatic build_table();
		reg_addr_t idx [4];
		idx[0] = 8'h00;
		idx[1] = 8'h0F;
		idx[2] = 8'h80;
		idx[3] = 8'hFF;
		for (int k = 0; k < 256; k++)
			shadow_model[k] = word_t'($random(seed));
		// arming by the boot loader
		add_step("status before arm", OP_READ, 1'b1, MODE_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("rom before arm", OP_READ, 1'b1, ROM_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("boot rom write", OP_WRITE, 1'b1, ROM_BYTE, 16'h4E71, 0, 1'b0, 1'b0, 1'b0);
		add_step("status after arm", OP_READ, 1'b1, STATUS1_BYTE, 0, 3, 1'b0, 1'b0, 1'b0);
		add_step("rom after arm", OP_READ, 1'b1, ROM_BYTE, 0, 0, 1'b1, 1'b0, 1'b0);
		// shadow filled from the register bus, read through the window
		for (int k = 0; k < 4; k++)
			add_step($sformatf("shadow write %h", idx[k]), OP_REGWR, 1'b0, {16'h0, idx[k]},
				shadow_model[idx[k]], 0, 1'b0, 1'b0, 1'b0);
		for (int k = 0; k < 4; k++)
			add_step($sformatf("shadow read %h", idx[k]), OP_READ, 1'b0,
				SHADOW_BASE | {15'd0, idx[k], 1'b0}, 0, shadow_model[idx[k]],
				1'b0, 1'b0, 1'b0);
		add_step("ram past window", OP_READ, 1'b0, RAM_BYTE, 0, 0, 1'b1, 1'b0, 1'b0);
		// freeze, handshake and overlay
		add_step("freeze edge", OP_FREEZE, 1'b0, 0, 0, 0, 1'b0, 1'b1, 1'b0);
		add_step("status after freeze", OP_READ, 1'b0, MODE_BYTE, 0, 0, 1'b0, 1'b1, 1'b0);
		add_step("freeze iack", OP_IACK, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("freeze iack low", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
		add_step("overlay read", OP_READ, 1'b0, LOW_BYTE, 0, 0, 1'b1, 1'b0, 1'b1);
		add_step("freeze while active", OP_FREEZE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
		add_step("no int7 while active", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
		add_step("clear overlay", OP_WRITE, 1'b0, ROM_WORD3, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("low read no overlay", OP_READ, 1'b0, LOW_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		// leave the freeze and enter it again
		add_step("exit by mode write", OP_WRITE, 1'b0, MODE_BYTE, 3, 0, 1'b0, 1'b0, 1'b0);
		add_step("second freeze edge", OP_FREEZE, 1'b0, 0, 0, 0, 1'b0, 1'b1, 1'b0);
		add_step("second iack", OP_IACK, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("second iack low", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
		add_step("clear overlay again", OP_WRITE, 1'b0, ROM_WORD3, 0, 0, 1'b0, 1'b0, 1'b0);
		// breakpoint enabled, then disabled
		add_step("mode break on", OP_WRITE, 1'b0, MODE_BYTE, 2, 0, 1'b0, 1'b0, 1'b0);
		add_step("low area cycle", OP_READ, 1'b0, LOW_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("strobe gap", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("break access", OP_READ, 1'b0, BREAK_BYTE, 0, 0, 1'b0, 1'b1, 1'b0);
		add_step("status after break", OP_READ, 1'b0, MODE_BYTE, 0, 1, 1'b0, 1'b1, 1'b0);
		add_step("break iack", OP_IACK, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("break iack low", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
		add_step("clear break overlay", OP_WRITE, 1'b0, ROM_WORD3, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("mode break off", OP_WRITE, 1'b0, MODE_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("low area cycle off", OP_READ, 1'b0, LOW_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("strobe gap off", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("break access off", OP_READ, 1'b0, BREAK_BYTE, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("no break int7", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		// reset vector fetch after a new reset
		add_step("new reset", OP_RESET, 1'b1, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("re-arm", OP_WRITE, 1'b1, ROM_BYTE, 16'h4E71, 0, 1'b0, 1'b0, 1'b0);
		add_step("vector fetch", OP_READ, 1'b0, VEC_BYTE, 0, 0, 1'b0, 1'b1, 1'b0);
		add_step("vector iack", OP_IACK, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b0);
		add_step("vector iack low", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
		add_step("second vector fetch", OP_READ, 1'b0, VEC_BYTE, 0, 0, 1'b1, 1'b0, 1'b1);
		add_step("no vector int7", OP_IDLE, 1'b0, 0, 0, 0, 1'b0, 1'b0, 1'b1);
	endtask

	initial begin
		step_t s;
		logic  aron_exp;
		aron_exp = 1'b0;
		set_idle(1'b1);
		reset = 1'b1;
		build_table();
		cycle_limit = steps.size() * 8 + 20;
		pulse_reset();
		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			drive_step(s);
			// selects are combinational, sample mid-cycle
			#4;
			check_value(s.name, "selmem", 16'(s.exp_selmem), 16'(selmem));
			@(posedge clk);
			#1;
			// arm flag follows a boot write to the rom half, only reset clears it
			if (s.kind == OP_RESET)
				aron_exp = 1'b0;
			else if (s.kind == OP_WRITE && s.boot && s.addr[23:18] == ROM_BYTE[23:18])
				aron_exp = 1'b1;
			check_value(s.name, "data_out", s.exp_data, data_out);
			check_value(s.name, "int7", 16'(s.exp_int7), 16'(int7));
			check_value(s.name, "ovr", 16'(s.exp_ovr), 16'(ovr));
			check_value(s.name, "aron", 16'(aron_exp), 16'(aron));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
cart_pkg.sv
cart_decode.sv
cart_regs.sv
cart_irq.sv
cart_break.sv
custom_shadow.sv
cart_top.sv
tb_cart.sv

/* run.sh */
#!/bin/sh
# build the cartridge testbench with Verilator, run it and search the log
rm -rf obj_dir build.log sim.log
verilator --binary --top-module tb_cart -f vlog.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_cart > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log 2>/dev/null \
	&& echo "run ok" \
	|| { cat build.log sim.log 2>/dev/null; echo "run failed"; exit 1; }
